//--- logic/isaPkg.sv
package isaPkg;

    typedef logic [31:0] wordT;                 // Datapath word
    typedef logic [4:0]  regIdxT;               // Register file index
    typedef logic [15:0] imm16T;                // I-type immediate field
    typedef logic [25:0] jumpIdxT;              // J-type target field

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OpRType = 6'b000000,                    // Uses funct
        OpLw    = 6'b010001,                    // Load word
        OpSw    = 6'b010000,                    // Store word
        OpSubiu = 6'b001101,                    // rt = rs - imm
        OpSlti  = 6'b101010,                    // Signed set on less than
        OpBeq   = 6'b010011,                    // Branch on equal
        OpJump  = 6'b011100                     // Absolute jump in region
    } opcodeT;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FnAddu = 6'b100001,                     // Wrapping add
        FnSubu = 6'b100011,                     // Wrapping subtract
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnSlt  = 6'b101010                      // Signed compare
    } functT;

    typedef struct packed {
        opcodeT opcode;                         // 31:26
        regIdxT rs;                             // 25:21
        regIdxT rt;                             // 20:16
        regIdxT rd;                             // 15:11
        logic [4:0] shamt;                      // 10:6 no shifter in core
        functT funct;                           // 5:0
    } instrT;

    function automatic imm16T immOf(instrT instr);
        return imm16T'(instr[15:0]);            // Overlays rd, shamt, funct
    endfunction

    function automatic jumpIdxT jumpIdxOf(instrT instr);
        return jumpIdxT'(instr[25:0]);          // Everything below opcode
    endfunction

endpackage

//--- logic/ctrlPkg.sv
package ctrlPkg;

    // Operation class from main control to the ALU
    typedef enum logic [1:0] {
        AluOpAdd   = 2'b00,                     // Address calc
        AluOpSub   = 2'b01,                     // SUBIU and BEQ compare
        AluOpFunct = 2'b10,                     // R-type, look at funct
        AluOpSlt   = 2'b11                      // SLTI
    } aluOpT;

    // Resolved ALU function after class and funct decode
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } aluFuncT;

endpackage

//--- logic/mainControl.sv
`timescale 1ns/1ps

module mainControl
(
    input  isaPkg::opcodeT opcode,
    output logic           regDst,
    output logic           branch,
    output logic           regW,
    output ctrlPkg::aluOpT aluOp,
    output logic           aluSrc,
    output logic           memW,
    output logic           memR,
    output logic           memToReg,
    output logic           jump
);

    import isaPkg::*;
    import ctrlPkg::*;

    always_comb
    begin
        // Safe defaults, anything unlisted becomes a no-op
        regDst   = 1'b0;                        // rt
        branch   = 1'b0;
        regW     = 1'b0;                        // No write back
        aluOp    = AluOpAdd;
        aluSrc   = 1'b0;                        // Register operand
        memW     = 1'b0;
        memR     = 1'b0;
        memToReg = 1'b0;                        // Result from ALU
        jump     = 1'b0;

        case (opcode)
            OpRType:
            begin
                regDst = 1'b1;                  // Result to rd
                regW   = 1'b1;
                aluOp  = AluOpFunct;            // ALU decodes funct
            end
            OpLw:
            begin
                regW     = 1'b1;                // Loaded word to rt
                aluSrc   = 1'b1;                // Base plus offset
                memR     = 1'b1;                // Only reader of dmem
                memToReg = 1'b1;
            end
            OpSw:
            begin
                aluSrc = 1'b1;                  // Base plus offset
                memW   = 1'b1;                  // Store rt
            end
            OpSubiu:
            begin
                regW   = 1'b1;
                aluOp  = AluOpSub;              // rs minus sign-extended imm
                aluSrc = 1'b1;
            end
            OpSlti:
            begin
                regW   = 1'b1;
                aluOp  = AluOpSlt;              // Signed compare against imm
                aluSrc = 1'b1;
            end
            OpBeq:
            begin
                branch = 1'b1;
                aluOp  = AluOpSub;              // rs - rt, zero means equal
                aluSrc = 1'b0;                  // Both operands from registers
            end
            OpJump:
            begin
                jump = 1'b1;                    // pcUnit builds the target
            end
            default:
            begin
                regW = 1'b0;                    // Unknown opcode, nothing changes
            end
        endcase
    end

    // A load and a store never share one instruction
    always_comb
    begin
        assert final (!(memW && memR))
        else $error("mainControl: memW and memR both set for opcode %b", opcode);
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu
(
    input  isaPkg::wordT   a,
    input  isaPkg::wordT   b,
    input  ctrlPkg::aluOpT aluOp,
    input  isaPkg::functT  funct,
    output isaPkg::wordT   result,
    output logic           zero
);

    import isaPkg::*;
    import ctrlPkg::*;

    aluFuncT aluFunc;                           // Resolved operation

    // Class decode, R-type defers to funct
    always_comb
    begin
        case (aluOp)
            AluOpAdd: aluFunc = AluAdd;
            AluOpSub: aluFunc = AluSub;
            AluOpSlt: aluFunc = AluSlt;
            AluOpFunct:
            begin
                case (funct)
                    FnAddu:  aluFunc = AluAdd;
                    FnSubu:  aluFunc = AluSub;
                    FnAnd:   aluFunc = AluAnd;
                    FnOr:    aluFunc = AluOr;
                    FnSlt:   aluFunc = AluSlt;
                    default: aluFunc = AluAdd;  // Unknown funct acts as add
                endcase
            end
            default: aluFunc = AluAdd;
        endcase
    end

    always_comb
    begin
        case (aluFunc)
            AluAdd:  result = a + b;            // Wraps, no overflow trap
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluSlt:  result = {31'b0, ($signed(a) < $signed(b))};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);               // Drives BEQ decision

    // Branch decisions rely on an exact zero flag
    always_comb
    begin
        assert final (zero == (result == '0))
        else $error("alu: zero flag %b disagrees with result %h", zero, result);
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile
(
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rdAddrA,
    input  isaPkg::regIdxT rdAddrB,
    input  isaPkg::regIdxT wrAddr,
    input  logic           wrEn,
    input  isaPkg::wordT   wrData,
    output isaPkg::wordT   rdDataA,
    output isaPkg::wordT   rdDataB
);

    import isaPkg::*;

    wordT regs [32];                            // Architectural registers

    // Synchronous write, register 0 never takes a value
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;                  // All registers start at zero
            end
        end
        else if (wrEn && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Read ports see a write from the previous cycle
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // Register 0 stays zero through every write that targets it
    assert property (@(posedge clk) disable iff (!rstN)
        (rdAddrA == '0) |-> (rdDataA == '0))
    else $error("regFile: port A read %h from register 0", rdDataA);

    assert property (@(posedge clk) disable iff (!rstN)
        (rdAddrB == '0) |-> (rdDataB == '0))
    else $error("regFile: port B read %h from register 0", rdDataB);

endmodule

//--- logic/wordMem.sv
`timescale 1ns/1ps

module wordMem
#(
    parameter int  depth  = 64,
    parameter type entryT = logic [31:0]
)
(
    input  logic                     clk,
    input  logic                     wrEn,
    input  logic [$clog2(depth)-1:0] wrIdx,
    input  logic [$clog2(depth)-1:0] rdIdx,
    input  entryT                    wrData,
    output entryT                    rdData
);

    entryT mem [depth];                         // Contents undefined until written

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            mem[wrIdx] <= wrData;               // Visible to reads next cycle
        end
    end

    assign rdData = mem[rdIdx];                 // Asynchronous read

    // Writes never land past the last entry
    assert property (@(posedge clk)
        wrEn |-> (int'(wrIdx) < depth))
    else $error("wordMem: write index %0d outside depth %0d", wrIdx, depth);

endmodule

//--- logic/pcUnit.sv
`timescale 1ns/1ps

module pcUnit
#(
    parameter int imemDepth = 64
)
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            runEn,
    input  logic            branch,
    input  logic            jump,
    input  logic            zero,
    input  isaPkg::imm16T   imm16,
    input  isaPkg::jumpIdxT jumpIdx,
    output isaPkg::wordT    pc
);

    import isaPkg::*;

    wordT pcPlus4;                              // Sequential successor
    wordT branchTarget;
    wordT jumpTarget;
    wordT pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};  // Word offset
    assign jumpTarget   = {pcPlus4[31:28], jumpIdx, 2'b00};          // Same 256 MB region

    always_comb
    begin
        if (jump)
            pcNext = jumpTarget;                // Jump wins over branch
        else if (branch && zero)
            pcNext = branchTarget;              // Taken BEQ
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pc <= '0;                           // Fetch starts at word 0
        else if (runEn)
            pc <= pcNext;                       // Holds while stalled
    end

    // Fetch address stays aligned and inside instruction memory
    assert property (@(posedge clk) disable iff (!rstN)
        (pc[1:0] == 2'b00) && ((pc >> 2) < imemDepth))
    else $error("pcUnit: pc %h misaligned or beyond imem", pc);

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
#(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
)
(
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         runEn,
    input  logic                         progWe,
    input  logic [$clog2(imemDepth)-1:0] progAddr,
    input  isaPkg::wordT                 progData,
    output isaPkg::wordT                 pc,
    output logic                         storeEn,
    output isaPkg::wordT                 storeAddr,
    output isaPkg::wordT                 storeData
);

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int iIdxW = $clog2(imemDepth);   // Instruction word index width
    localparam int dIdxW = $clog2(dmemDepth);   // Data word index width

    instrT  instr;                              // Current fetched instruction
    logic   regDst, branch, regW, aluSrc;
    logic   memW, memR, memToReg, jump;
    aluOpT  aluOp;
    logic   regWGated, memWGated;               // Only act while running
    wordT   rdDataA, rdDataB;
    imm16T  imm16;                              // Raw immediate field
    wordT   immExt, aluB, aluResult;
    logic   aluZero;
    wordT   dmemRdData, memData, wbData;
    regIdxT wrAddr;
    logic [dIdxW-1:0] dmemIdx;

    assign regWGated = regW & runEn;
    assign memWGated = memW & runEn;

    assign imm16   = immOf(instr);
    assign immExt  = {{16{imm16[15]}}, imm16};                // Sign extension
    assign aluB    = aluSrc ? immExt : rdDataB;
    assign wrAddr  = regDst ? instr.rd : instr.rt;            // R-type writes rd
    assign dmemIdx = aluResult[dIdxW+1:2];                    // Byte address to word
    assign memData = memR ? dmemRdData : '0;                  // Only LW sees memory
    assign wbData  = memToReg ? memData : aluResult;

    // Store port mirrors the data memory write side
    assign storeEn   = memWGated;
    assign storeAddr = aluResult;
    assign storeData = rdDataB;

    wordMem #(.depth(imemDepth), .entryT(instrT)) imem (
        .clk(clk), .wrEn(progWe), .wrIdx(progAddr), .rdIdx(pc[iIdxW+1:2]),
        .wrData(instrT'(progData)), .rdData(instr));

    mainControl ctrl (
        .opcode(instr.opcode), .regDst(regDst), .branch(branch), .regW(regW),
        .aluOp(aluOp), .aluSrc(aluSrc), .memW(memW), .memR(memR),
        .memToReg(memToReg), .jump(jump));

    regFile rf (
        .clk(clk), .rstN(rstN), .rdAddrA(instr.rs), .rdAddrB(instr.rt),
        .wrAddr(wrAddr), .wrEn(regWGated), .wrData(wbData),
        .rdDataA(rdDataA), .rdDataB(rdDataB));

    alu aluInst (
        .a(rdDataA), .b(aluB), .aluOp(aluOp), .funct(instr.funct),
        .result(aluResult), .zero(aluZero));

    wordMem #(.depth(dmemDepth), .entryT(wordT)) dmem (
        .clk(clk), .wrEn(memWGated), .wrIdx(dmemIdx), .rdIdx(dmemIdx),
        .wrData(rdDataB), .rdData(dmemRdData));

    pcUnit #(.imemDepth(imemDepth)) pcu (
        .clk(clk), .rstN(rstN), .runEn(runEn), .branch(branch), .jump(jump),
        .zero(aluZero), .imm16(imm16), .jumpIdx(jumpIdxOf(instr)), .pc(pc));

    // Program loading and execution never overlap
    assert property (@(posedge clk) disable iff (!rstN)
        !(progWe && runEn))
    else $error("cpuTop: imem written at %0d while core is running", progAddr);

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    import isaPkg::*;

    localparam int  imemDepth = 64;
    localparam int  dmemDepth = 64;
    localparam int  addrW     = $clog2(imemDepth);  // Load port index width
    localparam int  vecWords  = 256;                // Room for program plus store records
    localparam time clkPeriod = 100ns;

    logic             clk;
    logic             rstN;
    logic             runEn;
    logic             progWe;
    logic [addrW-1:0] progAddr;
    wordT             progData;
    wordT             pc;
    logic             storeEn;
    wordT             storeAddr;
    wordT             storeData;

    wordT vecMem [vecWords];                        // Raw vectors file image
    int   progLen;                                  // N instruction words
    int   storeCount;                               // S expected stores
    int   storeIdx;                                 // Next expected store
    bit   vecsReady;                                // Lengths known, watchdog may start

    cpuTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) uut (
        .clk(clk), .rstN(rstN), .runEn(runEn),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData));

    always #(clkPeriod / 2) clk = ~clk;             // 100 ns period

    // Wrong value seen, stop at once
    task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
        $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first mismatch");
    endtask

    // Any other failure, described in words
    task automatic abortRun(input string why);
        $display("ERROR: %s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        assert (actual === expected)                // X on the bus also fails
        else reportMismatch(name, expected, actual);
    endtask

    // Store records in the order the program makes them
    function automatic string storeName(input int idx);
        case (idx)
            0:       return "ADDU wraps";
            1:       return "SUBU negative";
            2:       return "AND";
            3:       return "OR";
            4:       return "SLT signed";
            5:       return "LW reload";
            6:       return "SW base plus offset";
            7:       return "SW negative offset";
            8:       return "SUBIU negative imm";
            9:       return "SLTI signed true";
            10:      return "SLTI signed false";
            11:      return "BEQ taken then not taken";
            12:      return "J and no-op";
            13:      return "register 0";
            default: return $sformatf("store %0d", idx);
        endcase
    endfunction

    task automatic checkStore();
        wordT expAddr;
        wordT expData;
        assert (storeIdx < storeCount)
        else abortRun($sformatf("core stored to %h after all %0d expected stores",
                                storeAddr, storeCount));
        expAddr = vecMem[progLen + 2 + 2 * storeIdx];   // Byte address
        expData = vecMem[progLen + 3 + 2 * storeIdx];
        checkWord({storeName(storeIdx), " address"}, expAddr, storeAddr);
        checkWord({storeName(storeIdx), " data"}, expData, storeData);
        storeIdx++;
    endtask

    // One word per edge through the load port, core stopped
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++)
        begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= addrW'(i);
            progData <= vecMem[i + 1];
        end
        @(posedge clk);
        progWe <= 1'b0;                             // Last word lands on this edge
        while (rstN !== 1'b1)
        begin
            @(posedge clk);                         // Short programs still wait out reset
        end
    endtask

    // Runs until pc stops moving, the final J to itself
    task automatic runProgram();
        wordT lastPc;
        bit   running;
        bit   looping;
        lastPc  = '0;
        running = 1'b0;
        looping = 1'b0;
        @(posedge clk);
        runEn <= 1'b1;
        while (!looping)
        begin
            @(posedge clk);                         // pc here is the instruction retiring
            if (storeEn)
            begin
                checkStore();
            end
            if (running && (pc == lastPc))
            begin
                looping = 1'b1;
            end
            lastPc  = pc;
            running = 1'b1;
        end
    endtask

    initial
    begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);                  // 8 cycles of reset
        rstN <= 1'b1;
    end

    initial
    begin
        clk       = 1'b0;
        runEn     = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        storeIdx  = 0;
        vecsReady = 1'b0;

        $readmemh("dv/cpuVectors.txt", vecMem);
        progLen = int'(vecMem[0]);
        assert (!$isunknown(vecMem[0]) && (progLen > 0) && (progLen <= imemDepth))
        else abortRun("vectors file holds no valid program length");
        storeCount = int'(vecMem[progLen + 1]);
        assert (!$isunknown(vecMem[progLen + 1]) && ((progLen + 2 + 2 * storeCount) <= vecWords))
        else abortRun("vectors file holds no valid store count");
        vecsReady = 1'b1;

        loadProgram();
        runProgram();

        // Self-loop sits in the last program word
        checkWord("final loop pc", wordT'((progLen - 1) * 4), pc);

        // Skipped stores show up as a short count
        assert (storeIdx == storeCount)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            reportMismatch("store count", wordT'(storeCount), wordT'(storeIdx));
        end
    end

    // Load time plus generous run time per instruction
    initial
    begin
        wait (vecsReady);
        repeat (progLen * 4 + 200) @(posedge clk);
        abortRun($sformatf("program never reached its final loop within %0d clock periods",
                           progLen * 4 + 200));
    end

endmodule

//--- dv/cpuVectors.txt
// Word 0 is program length N, then N instruction words, then store count S
// then S lines of expected store byte address and store data, all hex
00000022
3401FFFB 34020003                    // SUBIU r1 = 5, r2 = -3
00412021 00412823 00223024           // ADDU r4, SUBU r5, AND r6
00223825 0041402A                    // OR r7, SLT r8
40040000 40050004 40060008           // SW r4, r5, r6
4007000C 40080010                    // SW r7, r8
44090004 40090014                    // LW r9 from 0x04, SW r9 to 0x14
340AFFE0 41410004 4142FFFC           // r10 = 0x20, SW via +4 and -4
342BFFF9 A84C0001 A82DFFFF           // SUBIU r11 = 12, SLTI r12, SLTI r13
400B0028 400C002C 400D0030           // SW r11, r12, r13
4CC10001 40010034                    // BEQ taken, skipped SW
4C220001 40010038                    // BEQ not taken, SW r1
7000001D 4002003C                    // J over skipped SW
FC011234 40010040                    // Unknown opcode, SW r1
3420FFFF 40000044                    // SUBIU into r0, SW r0
70000021                             // J to itself
0000000E
00000000 00000002
00000004 FFFFFFF8
00000008 00000005
0000000C FFFFFFFD
00000010 00000001
00000014 FFFFFFF8
00000024 00000005
0000001C FFFFFFFD
00000028 0000000C
0000002C 00000001
00000030 00000000
00000038 00000005
00000040 00000005
00000044 00000000

//--- tb.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/mainControl.sv
logic/alu.sv
logic/regFile.sv
logic/wordMem.sv
logic/pcUnit.sv
logic/cpuTop.sv
dv/cpuTb.sv
